// ==== Makefile ====
# Verilator flow for the SPI slave register bridge

TOP := spi_slave_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) -Mdir obj_dir -f files.f

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Result: FAILED" sim.log; then exit 1; fi
	@grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== files.f ====
+incdir+.
spi_pkg.sv
spi_fe.sv
spi_regs.sv
spi_slave.sv
spi_slave_assert.sv
spi_slave_tb.sv

// ==== spi_consts.svh ====
`ifndef SPI_CONSTS_SVH
`define SPI_CONSTS_SVH

// frame format seen on the SPI pins
`define SPI_FRAME_W  16 // bits per ss low period
`define SPI_ADDR_W   3  // register address field
`define SPI_DATA_W   8  // register width

// register map
`define SPI_NUM_REGS 8  // total addressable registers
`define SPI_NUM_CTRL 6  // writable ones, from address 0 up

// everything above NUM_CTRL is read-only status
// frame bits left over between address and data are reserved

`endif

// ==== spi_fe.sv ====
`timescale 1ns/1ps
`include "spi_consts.svh"

module spi_fe (
  input  logic                clk,
  input  logic                rst,
  input  logic                sclk,      // serial clock from master, mode 0
  input  logic                ss,        // slave select, active low
  input  logic                mosi,      // master out slave in
  output logic                miso,      // master in slave out, never tri-stated
  input  spi_pkg::spi_reply_t reply,     // sampled at frame start
  output spi_pkg::spi_cmd_t   cmd,       // last received word
  output logic                cmd_valid  // one-cycle strobe per complete frame
);

  import spi_pkg::*;

  localparam int CNT_W = $clog2(`SPI_FRAME_W) + 1; // headroom to see long frames

  logic [2:0]       sclk_q;    // [1:0] sync, [2] edge flop
  logic [2:0]       ss_q;      // same layout as sclk_q
  logic [1:0]       mosi_q;    // data delayed like sclk
  logic             sclk_rise; // registered edge strobes
  logic             sclk_fall;
  logic             ss_rise;
  logic             ss_fall;
  logic             ss_low;    // frame in progress
  logic [CNT_W-1:0] bit_cnt;   // sclk rises seen this frame
  spi_cmd_t         rx_q;      // receive shifter
  spi_reply_t       tx_q;      // transmit shifter

  // pin synchronizers, idle bus is ss high and sclk low
  always_ff @(posedge clk) begin
    if (rst) begin
      sclk_q <= '0;
      ss_q   <= '1;
    end else begin
      sclk_q <= {sclk_q[1:0], sclk};
      ss_q   <= {ss_q[1:0], ss}; // sampled every clk
    end
  end

  always_ff @(posedge clk) begin
    mosi_q <= {mosi_q[0], mosi}; // stable around sclk rise
  end

  // edges are flagged one cycle after the edge flop, three after the pin
  always_ff @(posedge clk) begin
    if (rst) begin
      sclk_rise <= 1'b0;
      sclk_fall <= 1'b0;
      ss_rise   <= 1'b0;
      ss_fall   <= 1'b0;
    end else begin
      sclk_rise <= sclk_q[1] & ~sclk_q[2];
      sclk_fall <= ~sclk_q[1] & sclk_q[2];
      ss_rise   <= ss_q[1] & ~ss_q[2];
      ss_fall   <= ~ss_q[1] & ss_q[2];
    end
  end

  assign ss_low = ~ss_q[2]; // low already when ss_fall fires

  // bit counter, saturates so long frames never wrap back to 16
  always_ff @(posedge clk) begin
    if (rst) begin
      bit_cnt <= '0;
    end else if (ss_fall) begin
      bit_cnt <= '0;
    end else if (ss_low && sclk_rise && bit_cnt != '1) begin
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  // mosi sampled on sclk rise, msb first
  always_ff @(posedge clk) begin
    if (ss_low && sclk_rise) begin
      rx_q <= {rx_q[`SPI_FRAME_W-2:0], mosi_q[1]};
    end
  end

  // reply loaded at frame start, advanced on sclk fall
  always_ff @(posedge clk) begin
    if (rst) begin
      tx_q <= '0;
    end else if (ss_fall) begin
      tx_q <= reply;
    end else if (ss_low && sclk_fall) begin
      tx_q <= {tx_q[`SPI_FRAME_W-2:0], 1'b0};
    end
  end

  // only exact-length frames go on to the register block
  always_ff @(posedge clk) begin
    if (rst) begin
      cmd_valid <= 1'b0;
    end else begin
      cmd_valid <= ss_rise && (bit_cnt == CNT_W'(`SPI_FRAME_W));
    end
  end

  assign cmd  = rx_q;                  // holds until the next frame shifts
  assign miso = tx_q[`SPI_FRAME_W-1];  // master samples on its sclk rise

endmodule

// ==== spi_pkg.sv ====
`include "spi_consts.svh"

package spi_pkg;

  typedef logic [`SPI_DATA_W-1:0] spi_data_t; // one register value
  typedef logic [`SPI_ADDR_W-1:0] spi_addr_t; // register index

  // received frame, msb first on the wire
  typedef struct packed {
    logic                                            wr;    // 1 = write
    spi_addr_t                                       addr;  // target register
    logic [`SPI_FRAME_W-`SPI_ADDR_W-`SPI_DATA_W-2:0] rsvd;  // ignored
    spi_data_t                                       wdata; // write payload
  } spi_cmd_t;

  // answer shifted out during the following frame
  typedef struct packed {
    logic                                            wr;    // echo of write flag
    spi_addr_t                                       addr;  // echo of address
    logic [`SPI_FRAME_W-`SPI_ADDR_W-`SPI_DATA_W-2:0] zero;  // always 0
    spi_data_t                                       rdata; // value after the command
  } spi_reply_t;

  // control bank, entry i is register i
  typedef spi_data_t [`SPI_NUM_CTRL-1:0] spi_ctrl_t;

  // status words, entry 0 answers the first address past the control bank
  typedef spi_data_t [`SPI_NUM_REGS-`SPI_NUM_CTRL-1:0] spi_status_t;

endpackage

// ==== spi_regs.sv ====
`timescale 1ns/1ps
`include "spi_consts.svh"

module spi_regs (
  input  logic                 clk,
  input  logic                 rst,
  input  spi_pkg::spi_cmd_t    cmd,       // valid with cmd_valid
  input  logic                 cmd_valid, // strobe, taken in one cycle
  input  spi_pkg::spi_status_t status,    // read-only words, live
  output spi_pkg::spi_ctrl_t   ctrl,      // control registers out
  output spi_pkg::spi_reply_t  reply      // answer for the next frame
);

  import spi_pkg::*;

  localparam int NUM_STAT = `SPI_NUM_REGS - `SPI_NUM_CTRL; // status words

  logic [`SPI_NUM_CTRL-1:0] wr_sel;  // one-hot write enable
  spi_data_t                rdata;   // register value after the command
  spi_reply_t               reply_d; // reply for the current command

  // address decode for the control bank
  always_comb begin
    wr_sel = '0;
    for (int i = 0; i < `SPI_NUM_CTRL; i++) begin
      wr_sel[i] = cmd.wr && (cmd.addr == spi_addr_t'(i));
    end
  end

  // read mux, a write shows its own data
  always_comb begin
    rdata = '0;
    for (int i = 0; i < `SPI_NUM_CTRL; i++) begin
      if (cmd.addr == spi_addr_t'(i)) begin
        rdata = cmd.wr ? cmd.wdata : ctrl[i];
      end
    end
    for (int i = 0; i < NUM_STAT; i++) begin
      if (cmd.addr == spi_addr_t'(`SPI_NUM_CTRL + i)) begin
        rdata = status[i]; // status sampled in the cmd_valid cycle
      end
    end
  end

  // reply echoes the command header
  always_comb begin
    reply_d       = '0;
    reply_d.wr    = cmd.wr;
    reply_d.addr  = cmd.addr;
    reply_d.zero  = '0;
    reply_d.rdata = rdata;
  end

  // control bank, writes above the bank fall through wr_sel
  always_ff @(posedge clk) begin
    if (rst) begin
      ctrl <= '0;
    end else if (cmd_valid) begin
      for (int i = 0; i < `SPI_NUM_CTRL; i++) begin
        if (wr_sel[i]) begin
          ctrl[i] <= cmd.wdata;
        end
      end
    end
  end

  // reply updates together with ctrl
  always_ff @(posedge clk) begin
    if (rst) begin
      reply <= '0; // first frame after reset reads zeros
    end else if (cmd_valid) begin
      reply <= reply_d;
    end
  end

endmodule

// ==== spi_slave.sv ====
`timescale 1ns/1ps
`include "spi_consts.svh"

module spi_slave (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 sclk,   // SPI clock, at most clk/8
  input  logic                 ss,     // active low frame select
  input  logic                 mosi,
  output logic                 miso,
  input  spi_pkg::spi_status_t status, // read back at the top addresses
  output spi_pkg::spi_ctrl_t   ctrl    // writable register bank
);

  import spi_pkg::*;

  spi_cmd_t   cmd;       // word from the front end
  logic       cmd_valid; // full 16-bit frame seen
  spi_reply_t reply;     // loaded into miso shifter at ss fall

  // pin side, oversampled by clk
  spi_fe spi_fe_inst (
    .clk       (clk),
    .rst       (rst),
    .sclk      (sclk),
    .ss        (ss),
    .mosi      (mosi),
    .miso      (miso),
    .reply     (reply),
    .cmd       (cmd),
    .cmd_valid (cmd_valid)
  );

  // register bank and reply builder
  spi_regs spi_regs_inst (
    .clk       (clk),
    .rst       (rst),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .status    (status),
    .ctrl      (ctrl),
    .reply     (reply)
  );

endmodule

// ==== spi_slave_assert.sv ====
`timescale 1ns/1ps

module spi_slave_assert (
  input logic               clk,
  input logic               rst,
  input logic               cmd_valid, // front end strobe
  input spi_pkg::spi_ctrl_t ctrl       // register bank output
);

  // one strobe per frame, never back to back
  strobe_single: assert property (@(posedge clk) disable iff (rst) cmd_valid |=> !cmd_valid)
    else $error("cmd_valid high on two consecutive cycles");

  // synchronous reset clears the strobe
  strobe_reset: assert property (@(posedge clk) rst |=> !cmd_valid)
    else $error("cmd_valid high after a reset cycle");

  // registers move only on an accepted command
  ctrl_on_cmd: assert property (@(posedge clk) disable iff (rst)
                                !$stable(ctrl) |-> $past(cmd_valid))
    else $error("ctrl changed without a preceding cmd_valid");

endmodule

bind spi_slave spi_slave_assert spi_slave_assert_inst (
  .clk       (clk),
  .rst       (rst),
  .cmd_valid (cmd_valid),
  .ctrl      (ctrl)
);

// ==== spi_slave_tb.sv ====
`timescale 1ns/1ps
`include "spi_consts.svh"

module spi_slave_tb;

  import spi_pkg::*;

  localparam int HALF_SCLK  = 4;   // clk cycles per sclk half period
  localparam int SS_GAP     = 8;   // clk cycles of ss high after a frame
  localparam int CTRL_DELAY = 5;   // ss pin rise to ctrl update
  localparam int NUM_RANDOM = 200; // mixed frames in the random phase

  logic        clk;
  logic        rst;
  logic        sclk;
  logic        ss;
  logic        mosi;
  logic        miso;
  spi_status_t status;
  spi_ctrl_t   ctrl;

  spi_ctrl_t   ref_ctrl;    // model of the control bank
  spi_reply_t  ref_last;    // reply expected in the next frame
  spi_ctrl_t   ctrl_mid;    // ctrl seen one cycle before the update
  spi_ctrl_t   ctrl_late;   // ctrl seen in the update cycle
  int          valid_cycle; // cycle after ss rise where cmd_valid showed, 0 if none

  spi_slave spi_slave_inst (
    .clk    (clk),
    .rst    (rst),
    .sclk   (sclk),
    .ss     (ss),
    .mosi   (mosi),
    .miso   (miso),
    .status (status),
    .ctrl   (ctrl)
  );

  always #4 clk = ~clk; // 8 ns period

  task automatic fail_run();
    $display("Result: FAILED");
    $fatal(1, "stopping at first failure");
  endtask

  task automatic check_reply(input string name, input spi_reply_t exp, input spi_reply_t act);
    if (act !== exp) begin
      $display("error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      fail_run();
    end
  endtask

  task automatic check_ctrl(input string name, input spi_ctrl_t exp, input spi_ctrl_t act);
    if (act !== exp) begin
      $display("error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      fail_run();
    end
  endtask

  // n rising edges, then 1 ns so drives land after the edge
  task automatic wait_clocks(input int n);
    for (int k = 0; k < n; k++) begin
      @(posedge clk);
    end
    #1;
  endtask

  // expected reply for a complete frame, model updated as a side effect
  function automatic spi_reply_t ref_frame(input spi_cmd_t c);
    spi_reply_t r;
    r      = '0;
    r.wr   = c.wr;
    r.addr = c.addr;
    if (c.addr < spi_addr_t'(`SPI_NUM_CTRL)) begin
      if (c.wr) begin
        ref_ctrl[c.addr] = c.wdata; // control registers are writable
      end
      r.rdata = ref_ctrl[c.addr];
    end else begin
      r.rdata = status[1'(c.addr - spi_addr_t'(`SPI_NUM_CTRL))]; // read-only
    end
    ref_last = r;
    return r;
  endfunction

  // random reserved bits, fields overwritten
  function automatic spi_cmd_t make_cmd(input logic wr, input int addr, input spi_data_t data);
    spi_cmd_t c;
    c       = spi_cmd_t'(16'($urandom));
    c.wr    = wr;
    c.addr  = spi_addr_t'(addr);
    c.wdata = data;
    return c;
  endfunction

  // SPI master, mode 0, msb first, extra bits past 16 are random
  task automatic spi_frame(input spi_cmd_t word, input int nbits, output spi_reply_t rx);
    logic [`SPI_FRAME_W-1:0] bits;
    logic [`SPI_FRAME_W-1:0] rx_bits;
    bits        = word;
    rx_bits     = '0;
    valid_cycle = 0;
    ss          = 1'b0;
    wait_clocks(HALF_SCLK); // lets the slave load its reply
    for (int i = 0; i < nbits; i++) begin
      mosi = bits[`SPI_FRAME_W-1];
      bits = {bits[`SPI_FRAME_W-2:0], 1'($urandom)};
      wait_clocks(HALF_SCLK);
      sclk = 1'b1;
      if (i < `SPI_FRAME_W) begin
        rx_bits = {rx_bits[`SPI_FRAME_W-2:0], miso}; // capture on rise
      end
      wait_clocks(HALF_SCLK);
      sclk = 1'b0;
    end
    if (nbits < `SPI_FRAME_W) begin
      rx_bits = rx_bits << (`SPI_FRAME_W - nbits); // align to msb
    end
    rx = rx_bits;
    wait_clocks(HALF_SCLK);
    ss = 1'b1;
    // bounded watch for the strobe and the ctrl update
    for (int n = 1; n <= SS_GAP; n++) begin
      @(posedge clk);
      #1;
      if (spi_slave_inst.cmd_valid && valid_cycle == 0) begin
        valid_cycle = n;
      end
      if (n == CTRL_DELAY - 1) begin
        ctrl_mid = ctrl;
      end
      if (n == CTRL_DELAY) begin
        ctrl_late = ctrl;
      end
    end
  endtask

  // one frame with all its checks
  task automatic run_frame(input spi_cmd_t c, input int nbits);
    spi_reply_t              exp_reply;
    spi_reply_t              got_reply;
    spi_ctrl_t               old_ctrl;
    logic [`SPI_FRAME_W-1:0] mask;
    exp_reply = ref_last; // answers the last complete frame
    old_ctrl  = ref_ctrl;
    spi_frame(c, nbits, got_reply);
    mask = '1;
    if (nbits < `SPI_FRAME_W) begin
      mask = mask << (`SPI_FRAME_W - nbits); // only bits clocked out
    end
    check_reply("miso reply", spi_reply_t'(exp_reply & mask), spi_reply_t'(got_reply & mask));
    if (nbits == `SPI_FRAME_W) begin
      if (valid_cycle == 0) begin
        $display("timeout: no cmd_valid pulse within %0d cycles after ss rose", SS_GAP);
        fail_run();
      end
      void'(ref_frame(c));
    end else if (valid_cycle != 0) begin
      $display("cmd_valid pulsed for a dropped frame of %0d bits", nbits);
      fail_run();
    end
    check_ctrl("ctrl 4 cycles after ss rise", old_ctrl, ctrl_mid);
    check_ctrl("ctrl 5 cycles after ss rise", ref_ctrl, ctrl_late);
  endtask

  initial begin
    int pick;
    int nbits;
    clk         = 1'b0;
    rst         = 1'b1;
    sclk        = 1'b0;
    ss          = 1'b1;
    mosi        = 1'b0;
    status      = '0;
    ref_ctrl    = '0;
    ref_last    = '0;
    ctrl_mid    = '0;
    ctrl_late   = '0;
    valid_cycle = 0;
    void'($urandom(83));

    wait_clocks(4); // reset held for 4 cycles
    rst = 1'b0;
    wait_clocks(2);

    // reset state, first reply must be zero
    check_ctrl("ctrl after reset", '0, ctrl);
    run_frame(make_cmd(1'b0, 0, '0), `SPI_FRAME_W);

    // writes to the control bank
    for (int a = 0; a < `SPI_NUM_CTRL; a++) begin
      run_frame(make_cmd(1'b1, a, spi_data_t'($urandom)), `SPI_FRAME_W);
    end

    // read back, wdata field is junk
    for (int a = 0; a < `SPI_NUM_CTRL; a++) begin
      run_frame(make_cmd(1'b0, a, spi_data_t'($urandom)), `SPI_FRAME_W);
    end

    // status words, reads then ignored writes
    status = spi_status_t'(16'($urandom));
    for (int a = `SPI_NUM_CTRL; a < `SPI_NUM_REGS; a++) begin
      run_frame(make_cmd(1'b0, a, spi_data_t'($urandom)), `SPI_FRAME_W);
    end
    for (int a = `SPI_NUM_CTRL; a < `SPI_NUM_REGS; a++) begin
      run_frame(make_cmd(1'b1, a, spi_data_t'($urandom)), `SPI_FRAME_W);
    end

    // short and long frames are dropped
    run_frame(make_cmd(1'b1, 2, spi_data_t'($urandom)), 12);
    run_frame(make_cmd(1'b1, 3, spi_data_t'($urandom)), 20);
    run_frame(make_cmd(1'b0, 1, '0), `SPI_FRAME_W); // still answers the status write

    // random mix, now and then a bad length or new status
    for (int f = 0; f < NUM_RANDOM; f++) begin
      pick  = int'($urandom_range(9, 0));
      nbits = `SPI_FRAME_W;
      if (pick == 0) begin
        nbits = int'($urandom_range(23, 9));
        if (nbits == `SPI_FRAME_W) begin
          nbits = `SPI_FRAME_W + 1;
        end
      end
      if (pick == 1) begin
        status = spi_status_t'(16'($urandom));
      end
      run_frame(make_cmd(1'($urandom), int'($urandom_range(7, 0)), spi_data_t'($urandom)),
                nbits);
    end
    run_frame(make_cmd(1'b0, 0, '0), `SPI_FRAME_W); // flushes the last reply

    $display("Result: PASSED");
    $finish;
  end

endmodule
